//--- hdl/uart_settings.svh
// Bit period is UART_CLK_HZ / UART_BAUD rounded down; it must come out at 4 clocks or more
`ifndef UART_SETTINGS_SVH
`define UART_SETTINGS_SVH

////////////////////////////////////////
// Clock and line rate
////////////////////////////////////////

// 10 MHz system clock keeps simulated frames short
`define UART_CLK_HZ 10_000_000

// Line rate in bits per second
`define UART_BAUD 1_000_000

// Clocks per bit on the line
`define UART_BIT_CYCLES (`UART_CLK_HZ / `UART_BAUD)

`endif

//--- hdl/uart_pkg.sv
// Shared types only; field order of uart_status_t is the STATUS register layout
package uart_pkg;

   // One data byte on the line
   typedef logic [7:0] uart_byte_t;

   // STATUS register, bit 7 down to bit 0:
   // 7..5 zero, 4 frame error, 3 rx overrun, 2 tx overrun, 1 rx valid, 0 tx busy
   typedef struct packed {
      logic [2:0] unused;
      logic       frame_err;
      logic       rx_overrun;
      logic       tx_overrun;
      logic       rx_valid;
      logic       tx_busy;
   } uart_status_t;

   // Register addresses, 3 is unmapped
   typedef enum logic [1:0] {
      REG_DATA   = 2'd0,
      REG_STATUS = 2'd1,
      REG_CTRL   = 2'd2
   } uart_reg_e;

   typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;

   typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

endpackage

//--- hdl/uart_tx.sv
// 8N1 only; a load is taken only in idle while enabled, and dropping enable aborts the frame
`timescale 1ns/1ps
`include "uart_settings.svh"

module uart_tx (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 enable,
   input  logic                 tx_load,
   input  uart_pkg::uart_byte_t tx_byte,
   output logic                 tx_busy,
   output logic                 tx_out
);
   import uart_pkg::*;

   localparam int CNT_W = $clog2(`UART_BIT_CYCLES);
   localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(`UART_BIT_CYCLES - 1);

   tx_state_e        state;
   logic [CNT_W-1:0] bit_time;
   logic [2:0]       bit_idx;
   uart_byte_t       tx_shift;
   logic             bit_end;

   assign bit_end = (bit_time == BIT_LAST);

   // Busy straight from the state register, so no glitches
   assign tx_busy = (state != TX_IDLE);

   ////////////////////////////////////////
   // Bit period timer
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset || !enable || state == TX_IDLE || bit_end) begin
         bit_time <= '0;
      end else begin
         bit_time <= bit_time + CNT_W'(1);
      end
   end

   // Low bit always holds the next data bit to put on the line
   always_ff @(posedge clk) begin
      if (state == TX_IDLE && tx_load) begin
         tx_shift <= tx_byte;
      end else if (bit_end && (state == TX_START || state == TX_DATA)) begin
         tx_shift <= {1'b0, tx_shift[7:1]};
      end
   end

   ////////////////////////////////////////
   // Frame FSM and line register
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset || !enable) begin
         state   <= TX_IDLE;
         bit_idx <= '0;
         tx_out  <= 1'b1;
      end else begin
         case (state)
            TX_IDLE: begin
               if (tx_load) begin
                  state  <= TX_START;
                  tx_out <= 1'b0;
               end
            end
            TX_START: begin
               if (bit_end) begin
                  state   <= TX_DATA;
                  bit_idx <= '0;
                  tx_out  <= tx_shift[0];
               end
            end
            TX_DATA: begin
               if (bit_end) begin
                  if (bit_idx == 3'd7) begin
                     state  <= TX_STOP;
                     tx_out <= 1'b1;
                  end else begin
                     bit_idx <= bit_idx + 3'd1;
                     tx_out  <= tx_shift[0];
                  end
               end
            end
            TX_STOP: begin
               // Line is already high, busy drops when the stop bit ends
               if (bit_end) begin
                  state <= TX_IDLE;
               end
            end
            default: begin
               state  <= TX_IDLE;
               tx_out <= 1'b1;
            end
         endcase
      end
   end

endmodule

//--- hdl/uart_rx.sv
// 8N1 only; rx_byte is valid with rx_done and changes again once the next frame starts
`timescale 1ns/1ps
`include "uart_settings.svh"

module uart_rx (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 enable,
   input  logic                 rx_in,
   output logic                 rx_done,
   output logic                 rx_frame_err,
   output uart_pkg::uart_byte_t rx_byte
);
   import uart_pkg::*;

   localparam int CNT_W = $clog2(`UART_BIT_CYCLES);
   localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(`UART_BIT_CYCLES - 1);
   localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(`UART_BIT_CYCLES / 2 - 1);

   rx_state_e        state;
   logic [CNT_W-1:0] bit_time;
   logic [2:0]       bit_idx;
   uart_byte_t       rx_shift;
   logic             rx_meta;
   logic             rx_sync;
   logic             rx_prev;
   logic             sample;
   logic             fall;

   ////////////////////////////////////////
   // Line synchronizer
   ////////////////////////////////////////

   // Idle line is high, so reset to 1 to avoid a false start
   always_ff @(posedge clk) begin
      if (reset) begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
         rx_prev <= 1'b1;
      end else begin
         rx_meta <= rx_in;
         rx_sync <= rx_meta;
         rx_prev <= rx_sync;
      end
   end

   assign fall = rx_prev && !rx_sync;

   // Half a bit to the start bit middle, then whole bits
   assign sample = (state == RX_START) ? (bit_time == HALF_LAST) : (bit_time == BIT_LAST);

   ////////////////////////////////////////
   // Sample timer
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset || !enable || state == RX_IDLE || sample) begin
         bit_time <= '0;
      end else begin
         bit_time <= bit_time + CNT_W'(1);
      end
   end

   // LSB arrives first, so shift in from the top
   always_ff @(posedge clk) begin
      if (state == RX_DATA && sample) begin
         rx_shift <= {rx_sync, rx_shift[7:1]};
      end
   end

   assign rx_byte = rx_shift;

   ////////////////////////////////////////
   // Frame FSM
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset || !enable) begin
         state        <= RX_IDLE;
         bit_idx      <= '0;
         rx_done      <= 1'b0;
         rx_frame_err <= 1'b0;
      end else begin
         rx_done      <= 1'b0;
         rx_frame_err <= 1'b0;
         case (state)
            RX_IDLE: begin
               if (fall) begin
                  state <= RX_START;
               end
            end
            RX_START: begin
               if (sample) begin
                  // High again at mid-bit means a glitch, not a start bit
                  if (!rx_sync) begin
                     state   <= RX_DATA;
                     bit_idx <= '0;
                  end else begin
                     state <= RX_IDLE;
                  end
               end
            end
            RX_DATA: begin
               if (sample) begin
                  if (bit_idx == 3'd7) begin
                     state <= RX_STOP;
                  end else begin
                     bit_idx <= bit_idx + 3'd1;
                  end
               end
            end
            RX_STOP: begin
               if (sample) begin
                  state <= RX_IDLE;
                  if (rx_sync) begin
                     rx_done <= 1'b1;
                  end else begin
                     rx_frame_err <= 1'b1;
                  end
               end
            end
            default: begin
               state <= RX_IDLE;
            end
         endcase
      end
   end

endmodule

//--- hdl/uart_wb_regs.sv
// Wishbone classic, one wait state per access; writes to a busy or disabled transmitter are dropped
`timescale 1ns/1ps

module uart_wb_regs (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 wb_cyc,
   input  logic                 wb_stb,
   input  logic                 wb_we,
   input  logic [1:0]           wb_adr,
   input  logic [7:0]           wb_dat_w,
   output logic                 wb_ack,
   output logic [7:0]           wb_dat_r,
   input  logic                 tx_busy,
   input  logic                 rx_done,
   input  logic                 rx_frame_err,
   input  uart_pkg::uart_byte_t rx_byte,
   output logic                 tx_enable,
   output logic                 rx_enable,
   output logic                 tx_load,
   output uart_pkg::uart_byte_t tx_byte
);
   import uart_pkg::*;

   uart_reg_e    adr;
   uart_status_t status;
   uart_byte_t   rx_hold;
   logic         access;
   logic         wr_access;
   logic         rd_access;
   logic         data_write;
   logic         data_read;
   logic         tx_accept;
   logic         rx_valid;
   logic         frame_err;
   logic         rx_overrun;
   logic         tx_overrun;

   ////////////////////////////////////////
   // Bus decode
   ////////////////////////////////////////

   // Ack is never high two cycles running, so a held strobe is taken once
   assign access    = wb_cyc && wb_stb && !wb_ack;
   assign wr_access = access && wb_we;
   assign rd_access = access && !wb_we;
   assign adr       = uart_reg_e'(wb_adr);

   assign data_write = wr_access && adr == REG_DATA;
   assign data_read  = rd_access && adr == REG_DATA;

   assign tx_accept = data_write && tx_enable && !tx_busy;

   assign status = '{unused:     3'b000,
                     frame_err:  frame_err,
                     rx_overrun: rx_overrun,
                     tx_overrun: tx_overrun,
                     rx_valid:   rx_valid,
                     tx_busy:    tx_busy};

   ////////////////////////////////////////
   // Control and status flags
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         wb_ack     <= 1'b0;
         tx_enable  <= 1'b0;
         rx_enable  <= 1'b0;
         tx_load    <= 1'b0;
         rx_valid   <= 1'b0;
         frame_err  <= 1'b0;
         rx_overrun <= 1'b0;
         tx_overrun <= 1'b0;
      end else begin
         wb_ack  <= access;
         tx_load <= tx_accept;
         if (wr_access && adr == REG_CTRL) begin
            tx_enable <= wb_dat_w[0];
            rx_enable <= wb_dat_w[1];
         end
         if (data_write && !tx_accept) begin
            tx_overrun <= 1'b1;
         end
         // Sticky errors clear on a STATUS read
         if (rd_access && adr == REG_STATUS) begin
            frame_err  <= 1'b0;
            rx_overrun <= 1'b0;
            tx_overrun <= 1'b0;
         end
         if (data_read) begin
            rx_valid <= 1'b0;
         end
         // Receiver events win over a clear in the same cycle
         if (rx_done) begin
            rx_valid <= 1'b1;
            if (rx_valid && !data_read) begin
               rx_overrun <= 1'b1;
            end
         end
         if (rx_frame_err) begin
            frame_err <= 1'b1;
         end
      end
   end

   // Payload registers and read data
   always_ff @(posedge clk) begin
      if (tx_accept) begin
         tx_byte <= wb_dat_w;
      end
      if (rx_done) begin
         rx_hold <= rx_byte;
      end
      if (rd_access) begin
         case (adr)
            REG_DATA:   wb_dat_r <= rx_hold;
            REG_STATUS: wb_dat_r <= status;
            REG_CTRL:   wb_dat_r <= {6'b000000, rx_enable, tx_enable};
            default:    wb_dat_r <= 8'h00;
         endcase
      end
   end

endmodule

//--- hdl/uart_top.sv
// Loopback is not built in; tie tx_out to rx_in outside when it is wanted
`timescale 1ns/1ps

module uart_top (
   input  logic       clk,
   input  logic       reset,
   input  logic       wb_cyc,
   input  logic       wb_stb,
   input  logic       wb_we,
   input  logic [1:0] wb_adr,
   input  logic [7:0] wb_dat_w,
   output logic [7:0] wb_dat_r,
   output logic       wb_ack,
   output logic       tx_out,
   input  logic       rx_in
);
   import uart_pkg::*;

   logic       tx_enable;
   logic       rx_enable;
   logic       tx_load;
   logic       tx_busy;
   logic       rx_done;
   logic       rx_frame_err;
   uart_byte_t tx_byte;
   uart_byte_t rx_byte;

   // Bus side
   uart_wb_regs regs0 (
      .clk(clk), .reset(reset),
      .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
      .wb_dat_w(wb_dat_w), .wb_ack(wb_ack), .wb_dat_r(wb_dat_r),
      .tx_busy(tx_busy), .rx_done(rx_done), .rx_frame_err(rx_frame_err),
      .rx_byte(rx_byte), .tx_enable(tx_enable), .rx_enable(rx_enable),
      .tx_load(tx_load), .tx_byte(tx_byte)
   );

   uart_tx tx0 (
      .clk(clk), .reset(reset), .enable(tx_enable),
      .tx_load(tx_load), .tx_byte(tx_byte),
      .tx_busy(tx_busy), .tx_out(tx_out)
   );

   uart_rx rx0 (
      .clk(clk), .reset(reset), .enable(rx_enable), .rx_in(rx_in),
      .rx_done(rx_done), .rx_frame_err(rx_frame_err), .rx_byte(rx_byte)
   );

endmodule

//--- tb/uart_assert.sv
// Bound into uart_top; tx_busy is the internal wire between the register block and the transmitter
`timescale 1ns/1ps

module uart_assert (
   input logic clk,
   input logic reset,
   input logic wb_cyc,
   input logic wb_stb,
   input logic wb_ack,
   input logic tx_busy,
   input logic tx_out
);

   // Ack belongs to a live bus cycle
   ack_in_cycle: assert property (@(posedge clk) disable iff (reset)
      wb_ack |-> (wb_cyc && wb_stb))
      else $error("wb_ack raised without wb_cyc and wb_stb");

   ack_single: assert property (@(posedge clk) disable iff (reset)
      wb_ack |=> !wb_ack)
      else $error("wb_ack high on two consecutive clocks");

   // Line rests high between frames
   idle_high: assert property (@(posedge clk) disable iff (reset)
      !tx_busy |-> tx_out)
      else $error("tx_out low while the transmitter is idle");

endmodule

bind uart_top uart_assert assert0 (
   .clk(clk), .reset(reset), .wb_cyc(wb_cyc), .wb_stb(wb_stb),
   .wb_ack(wb_ack), .tx_busy(tx_busy), .tx_out(tx_out)
);

//--- tb/uart_tb.sv
// Bit timing comes from uart_settings.svh; rx_in is either looped from tx_out or driven here
`timescale 1ns/1ps
`include "uart_settings.svh"

module uart_tb;
   import uart_pkg::*;

   localparam int CLK_PERIOD  = 100;
   localparam int BIT_CYCLES  = `UART_BIT_CYCLES;
   localparam int POLL_LIMIT  = 8 * BIT_CYCLES;
   localparam int FRAMES      = 46;
   localparam int WATCHDOG_NS = (FRAMES * 12 + 50) * BIT_CYCLES * CLK_PERIOD;
   localparam uart_status_t CARE_ALL     = 8'hff;
   localparam uart_status_t CARE_NO_BUSY = 8'hfe;

   logic       clk;
   logic       reset;
   logic       wb_cyc;
   logic       wb_stb;
   logic       wb_we;
   logic [1:0] wb_adr;
   logic [7:0] wb_dat_w;
   logic [7:0] wb_dat_r;
   logic       wb_ack;
   logic       tx_out;
   logic       rx_in;
   logic       loop_sel;
   logic       line_drv;
   logic [31:0] rng_state = 32'h6dbf;
   int         checks = 0;
   int         errors = 0;
   uart_byte_t expect_q[$];

   assign rx_in = loop_sel ? tx_out : line_drv;

   uart_top dut0 (
      .clk(clk), .reset(reset), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
      .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
      .tx_out(tx_out), .rx_in(rx_in)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("ERROR: watchdog expired before the tests finished");
      $display("** FAIL **");
      $finish;
   end

   ////////////////////////////////////////
   // Stimulus helpers
   ////////////////////////////////////////

   // xorshift32
   function uart_byte_t random_byte();
      logic [31:0] x;
      x = rng_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rng_state = x;
      return x[7:0];
   endfunction

   function uart_status_t status_of(input logic fe, input logic ro, input logic to,
                                    input logic rv, input logic busy);
      uart_status_t s;
      s = '0;
      s.frame_err  = fe;
      s.rx_overrun = ro;
      s.tx_overrun = to;
      s.rx_valid   = rv;
      s.tx_busy    = busy;
      return s;
   endfunction

   // One classic cycle, held until ack
   task bus_cycle(input logic we, input logic [1:0] adr, input logic [7:0] dat,
                  output logic [7:0] rdat);
      int n;
      @(negedge clk);
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_dat_w = dat;
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (!wb_ack && n < 8);
      if (!wb_ack) begin
         errors++;
         $display("ERROR: no acknowledge for the access to address %0d", adr);
      end
      rdat = wb_dat_r;
      // Strobe stays up through the edge that samples ack
      @(negedge clk);
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task wb_write(input logic [1:0] adr, input logic [7:0] dat);
      logic [7:0] unused_rd;
      bus_cycle(1'b1, adr, dat, unused_rd);
   endtask

   task wb_read(input logic [1:0] adr, output logic [7:0] dat);
      bus_cycle(1'b0, adr, 8'h00, dat);
   endtask

   // Poll STATUS for receive valid, or for the transmitter going idle
   task poll_status(input logic for_rx, output uart_status_t st);
      logic [7:0] d;
      int n;
      n = 0;
      do begin
         wb_read(REG_STATUS, d);
         st = uart_status_t'(d);
         n++;
      end while ((for_rx ? !st.rx_valid : st.tx_busy) && n < POLL_LIMIT);
      if (for_rx ? !st.rx_valid : st.tx_busy) begin
         errors++;
         $display("ERROR: gave up polling STATUS for %s", for_rx ? "receive valid" : "tx idle");
      end
   endtask

   // Start bit, LSB first data, chosen stop level
   task send_frame(input uart_byte_t data, input logic stop_bit);
      logic [9:0] frame;
      frame = {stop_bit, data, 1'b0};
      @(negedge clk);
      for (int i = 0; i < 10; i++) begin
         line_drv = frame[i];
         repeat (BIT_CYCLES) @(negedge clk);
      end
      line_drv = 1'b1;
   endtask

   ////////////////////////////////////////
   // Checks
   ////////////////////////////////////////

   task check_byte(input string name, input uart_byte_t got, input uart_byte_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAILED %s: got 0x%h expected 0x%h", name, got, exp);
      end
   endtask

   task check_status(input string name, input uart_status_t got, input uart_status_t exp,
                     input uart_status_t care);
      checks++;
      if ((got & care) !== (exp & care)) begin
         errors++;
         $display("FAILED %s: got 0x%h expected 0x%h mask 0x%h", name, got, exp, care);
      end
   endtask

   task check_bit(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAILED %s: got 0x%h expected 0x%h", name, got, exp);
      end
   endtask

   ////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////

   initial begin
      uart_byte_t   b1;
      uart_byte_t   b2;
      logic [7:0]   d;
      uart_status_t st;
      reset    = 1'b1;
      wb_cyc   = 1'b0;
      wb_stb   = 1'b0;
      wb_we    = 1'b0;
      wb_adr   = 2'd0;
      wb_dat_w = 8'h00;
      loop_sel = 1'b0;
      line_drv = 1'b1;
      repeat (4) @(negedge clk);
      reset = 1'b0;

      // Reset values and CTRL readback
      check_bit("tx_out", tx_out, 1'b1);
      wb_read(REG_STATUS, d);
      check_status("status", uart_status_t'(d), '0, CARE_ALL);
      wb_read(REG_CTRL, d);
      check_byte("ctrl", d, 8'h00);
      for (int v = 0; v < 4; v++) begin
         wb_write(REG_CTRL, 8'(v));
         wb_read(REG_CTRL, d);
         check_byte("ctrl", d, 8'(v));
      end
      wb_write(2'd3, 8'hff);
      wb_read(2'd3, d);
      check_byte("unmapped", d, 8'h00);

      // Loopback, random bytes
      loop_sel = 1'b1;
      wb_write(REG_CTRL, 8'h03);
      for (int k = 0; k < 40; k++) begin
         poll_status(1'b0, st);
         b1 = random_byte();
         wb_write(REG_DATA, b1);
         expect_q.push_back(b1);
         poll_status(1'b1, st);
         check_status("status", st, status_of(1'b0, 1'b0, 1'b0, 1'b1, 1'b0), CARE_NO_BUSY);
         wb_read(REG_DATA, d);
         check_byte("rx_data", d, expect_q.pop_front());
         wb_read(REG_STATUS, d);
         check_status("status", uart_status_t'(d), '0, CARE_NO_BUSY);
      end

      // Write while busy is refused
      poll_status(1'b0, st);
      b1 = random_byte();
      b2 = random_byte();
      wb_write(REG_DATA, b1);
      expect_q.push_back(b1);
      wb_write(REG_DATA, b2);
      wb_read(REG_STATUS, d);
      check_status("status", uart_status_t'(d), status_of(1'b0, 1'b0, 1'b1, 1'b0, 1'b1),
                   CARE_ALL);
      wb_read(REG_STATUS, d);
      check_status("status", uart_status_t'(d), status_of(1'b0, 1'b0, 1'b0, 1'b0, 1'b1),
                   CARE_ALL);
      poll_status(1'b1, st);
      wb_read(REG_DATA, d);
      check_byte("rx_data", d, expect_q.pop_front());
      poll_status(1'b0, st);

      // Two frames without a read, newer byte kept
      loop_sel = 1'b0;
      b1 = random_byte();
      b2 = random_byte();
      send_frame(b1, 1'b1);
      send_frame(b2, 1'b1);
      expect_q.push_back(b1);
      expect_q.push_back(b2);
      expect_q.delete(0);
      repeat (BIT_CYCLES) @(negedge clk);
      wb_read(REG_STATUS, d);
      check_status("status", uart_status_t'(d), status_of(1'b0, 1'b1, 1'b0, 1'b1, 1'b0),
                   CARE_ALL);
      wb_read(REG_DATA, d);
      check_byte("rx_data", d, expect_q.pop_front());
      wb_read(REG_STATUS, d);
      check_status("status", uart_status_t'(d), '0, CARE_ALL);

      // Low stop bit, then a good frame
      send_frame(random_byte(), 1'b0);
      repeat (BIT_CYCLES) @(negedge clk);
      wb_read(REG_STATUS, d);
      check_status("status", uart_status_t'(d), status_of(1'b1, 1'b0, 1'b0, 1'b0, 1'b0),
                   CARE_ALL);
      b2 = random_byte();
      send_frame(b2, 1'b1);
      repeat (BIT_CYCLES) @(negedge clk);
      wb_read(REG_STATUS, d);
      check_status("status", uart_status_t'(d), status_of(1'b0, 1'b0, 1'b0, 1'b1, 1'b0),
                   CARE_ALL);
      wb_read(REG_DATA, d);
      check_byte("rx_data", d, b2);

      // Receiver off, looped frame is ignored
      loop_sel = 1'b1;
      wb_write(REG_CTRL, 8'h01);
      wb_write(REG_DATA, random_byte());
      poll_status(1'b0, st);
      repeat (2 * BIT_CYCLES) @(negedge clk);
      wb_read(REG_STATUS, d);
      check_status("status", uart_status_t'(d), '0, CARE_ALL);

      $display("checks=%0d errors=%0d", checks, errors);
      if (errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

//--- sim.f
+incdir+hdl
hdl/uart_pkg.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/uart_wb_regs.sv
hdl/uart_top.sv
tb/uart_assert.sv
tb/uart_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert -j 0 -f sim.f --top-module uart_tb -Mdir obj_dir -o uart_sim
out=$(./obj_dir/uart_sim 2>&1) || true
echo "$out"
echo "$out" | grep -qF -- '** PASS **'
